// File: common/rf_pkg.sv
// shared sizes and encodings for the 16x65 register file subsystem

package rf_pkg;

   ////////////////////
   // array geometry
   ////////////////////
   localparam int rf_width  = 65;   // bits per entry
   localparam int rf_depth  = 16;   // entries
   localparam int rf_addr_w = 4;    // log2 of depth

   // scan chain through the input flops
   // order from si to so is wr_a, csn_wr, di, csn_rd, rd_a
   localparam int scan_len = rf_addr_w + 1 + rf_width + 1 + rf_addr_w;   // 75

   // sampled read request to valid rd_data
   localparam int rd_latency = 2;

   ////////////////////
   // march engine
   ////////////////////
   // four march elements bracketed by idle and a drain of the read pipe
   typedef enum logic [2:0] {
      idle     = 3'd0,   // waiting for bist_start
      w_bg_up  = 3'd1,   // write background, ascending
      r_bg_up  = 3'd2,   // read background, ascending
      w_inv_dn = 3'd3,   // write inverse, descending
      r_inv_dn = 3'd4,   // read inverse, descending
      drain    = 3'd5,   // let the last reads reach the checker
      done     = 3'd6    // result valid, port back to functional use
   } march_state_t;

endpackage

// File: rf_array/rf_16x65.sv
`timescale 1ns/1ps

// 16x65 register file macro
// all request inputs go through one flop bank that doubles as the scan chain

module rf_16x65 #(
   parameter int RF_WIDTH = 65,
   parameter int RF_DEPTH = 16
) (
   input  logic                         rd_ssclk,
   input  logic                         arst_n,
   input  logic                         csn_rd,        // read select, active low
   input  logic                         csn_wr,        // write select, active low
   input  logic                         hold,          // freeze the input flops
   input  logic                         testmux_sel,   // bypass di_ff to rd_data
   input  logic                         scan_en,       // shift the input flops
   input  logic                         si,
   input  logic [$clog2(RF_DEPTH)-1:0]  rd_a,
   input  logic [$clog2(RF_DEPTH)-1:0]  wr_a,
   input  logic [RF_WIDTH-1:0]          di,
   output logic                         so,
   output logic [RF_WIDTH-1:0]          rd_data,
   output logic [RF_WIDTH-1:0]          listen_out
);

   localparam int AW        = $clog2(RF_DEPTH);
   localparam int CHAIN_LEN = AW + 1 + RF_WIDTH + 1 + AW;

   // chain bit positions, so end is bit 0
   localparam int RD_A_LSB   = 0;
   localparam int CSN_RD_BIT = AW;
   localparam int DI_LSB     = AW + 1;
   localparam int CSN_WR_BIT = AW + 1 + RF_WIDTH;
   localparam int WR_A_LSB   = AW + 2 + RF_WIDTH;

   if (CHAIN_LEN != rf_pkg::scan_len) begin : g_chain_len_chk
      $error("rf_16x65 scan chain length does not match rf_pkg::scan_len");
   end

   logic [AW-1:0]        rd_a_ff;
   logic [AW-1:0]        wr_a_ff;
   logic [RF_WIDTH-1:0]  di_ff;
   logic                 csn_rd_ff;
   logic                 csn_wr_ff;

   logic [CHAIN_LEN-1:0] chain_q;   // current flop bank as one vector
   logic [CHAIN_LEN-1:0] chain_d;   // next value of the bank

   logic [RF_WIDTH-1:0]  mem [RF_DEPTH];
   logic [RF_WIDTH-1:0]  array_out;
   logic                 rd_en;
   logic                 wr_en;

   ////////////////////
   // input flop bank
   ////////////////////
   assign chain_q = {wr_a_ff, csn_wr_ff, di_ff, csn_rd_ff, rd_a_ff};

   always_comb begin
      if (hold) begin
         chain_d = chain_q;                          // recirculate, hold beats scan
      end else if (scan_en) begin
         chain_d = {si, chain_q[CHAIN_LEN-1:1]};     // one bit toward so per cycle
      end else begin
         chain_d = {wr_a, csn_wr, di, csn_rd, rd_a}; // normal capture
      end
   end

   // chip selects come up inactive
   always_ff @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         csn_rd_ff <= 1'b1;
         csn_wr_ff <= 1'b1;
      end else begin
         csn_rd_ff <= chain_d[CSN_RD_BIT];
         csn_wr_ff <= chain_d[CSN_WR_BIT];
      end
   end

   always_ff @(posedge rd_ssclk) begin
      rd_a_ff <= chain_d[RD_A_LSB +: AW];
      di_ff   <= chain_d[DI_LSB +: RF_WIDTH];
      wr_a_ff <= chain_d[WR_A_LSB +: AW];
   end

   assign so = chain_q[0];   // tail of the chain, rd_a_ff[0]

   ////////////////////
   // storage array
   ////////////////////
   // no array access while the chain is shifting
   assign rd_en = !csn_rd_ff && !scan_en;
   assign wr_en = !csn_wr_ff && !scan_en;

   always_ff @(posedge rd_ssclk) begin
      if (wr_en) begin
         mem[wr_a_ff] <= di_ff;   // one edge after the request was sampled
      end
   end

   // registered read, idle port reads as all ones
   always_ff @(posedge rd_ssclk) begin
      if (rd_en) begin
         array_out <= mem[rd_a_ff];
      end else begin
         array_out <= '1;
      end
   end

   // test bypass shows the flopped write data
   assign rd_data = testmux_sel ? di_ff : array_out;

   // listen register, observes the output one cycle late
   always_ff @(posedge rd_ssclk) begin
      listen_out <= rd_data;
   end

   ////////////////////
   // checks
   ////////////////////
   // same-address read and write in one cycle gives old data on the read,
   // which the macro does not guarantee
   a_rw_collision : assert property (
      @(posedge rd_ssclk) disable iff (!arst_n)
         !(rd_en && wr_en && (rd_a_ff == wr_a_ff))
   ) else $error("rf_16x65: read and write to address %0d in the same cycle", rd_a_ff);

endmodule

// File: logic/mbist_ctrl.sv
`timescale 1ns/1ps

// march sequencer
// w_bg_up, r_bg_up, w_inv_dn, r_inv_dn, then drain until the last compare lands

module mbist_ctrl (
   input  logic                  rd_ssclk,
   input  logic                  arst_n,
   input  logic                  bist_start,   // one cycle pulse
   input  logic                  cnt_last,     // counter at end address
   output rf_pkg::march_state_t  state,
   output logic                  cnt_en,
   output logic                  cnt_down,     // direction for the next load
   output logic                  cnt_load,
   output logic                  bist_csn_rd,
   output logic                  bist_csn_wr,
   output logic                  bist_busy,
   output logic                  bist_done
);

   localparam int DRAIN_W = $clog2(rf_pkg::rd_latency + 1);

   rf_pkg::march_state_t state_d;
   logic [DRAIN_W-1:0]   drain_cnt;   // cycles spent in drain
   logic                 drain_end;

   assign drain_end = (drain_cnt == DRAIN_W'(rf_pkg::rd_latency));

   ////////////////////
   // next state
   ////////////////////
   always_comb begin
      state_d  = state;
      cnt_load = 1'b0;
      cnt_down = 1'b0;
      case (state)
         rf_pkg::idle, rf_pkg::done: begin
            if (bist_start) begin   // rerun allowed from done
               state_d  = rf_pkg::w_bg_up;
               cnt_load = 1'b1;     // start at address 0
            end
         end
         rf_pkg::w_bg_up: begin
            if (cnt_last) begin
               state_d  = rf_pkg::r_bg_up;
               cnt_load = 1'b1;
            end
         end
         rf_pkg::r_bg_up: begin
            if (cnt_last) begin
               state_d  = rf_pkg::w_inv_dn;
               cnt_load = 1'b1;
               cnt_down = 1'b1;     // descending from the top address
            end
         end
         rf_pkg::w_inv_dn: begin
            if (cnt_last) begin
               state_d  = rf_pkg::r_inv_dn;
               cnt_load = 1'b1;
               cnt_down = 1'b1;
            end
         end
         rf_pkg::r_inv_dn: begin
            if (cnt_last) state_d = rf_pkg::drain;
         end
         rf_pkg::drain: begin
            if (drain_end) state_d = rf_pkg::done;   // rd_latency+1 cycles
         end
         default: state_d = rf_pkg::idle;
      endcase
   end

   always_ff @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= rf_pkg::idle;
         drain_cnt <= '0;
      end else begin
         state <= state_d;
         if (state == rf_pkg::drain) drain_cnt <= drain_cnt + 1'b1;
         else                        drain_cnt <= '0;
      end
   end

   ////////////////////
   // port controls
   ////////////////////
   assign cnt_en      = (state == rf_pkg::w_bg_up)  || (state == rf_pkg::r_bg_up) ||
                        (state == rf_pkg::w_inv_dn) || (state == rf_pkg::r_inv_dn);
   assign bist_csn_wr = !((state == rf_pkg::w_bg_up) || (state == rf_pkg::w_inv_dn));
   assign bist_csn_rd = !((state == rf_pkg::r_bg_up) || (state == rf_pkg::r_inv_dn));
   assign bist_busy   = (state != rf_pkg::idle) && (state != rf_pkg::done);
   assign bist_done   = (state == rf_pkg::done);

   // fixed run length from start to done
   a_run_length : assert property (
      @(posedge rd_ssclk) disable iff (!arst_n)
         $rose(bist_busy) |-> ##(4 * rf_pkg::rf_depth + rf_pkg::rd_latency + 1) $rose(bist_done)
   ) else $error("mbist_ctrl: march did not finish in the expected cycle count");

endmodule

// File: logic/mbist_addr_cnt.sv
`timescale 1ns/1ps

// march address counter
// direction is latched at load so cnt_last never depends on the live request

module mbist_addr_cnt #(
   parameter int ADDR_W = 4
) (
   input  logic              rd_ssclk,
   input  logic              arst_n,
   input  logic              cnt_en,     // step one address
   input  logic              cnt_down,   // direction, sampled on load
   input  logic              cnt_load,   // jump to the start of an element
   output logic [ADDR_W-1:0] addr,
   output logic              cnt_last
);

   logic dir_dn;   // current element counts down

   always_ff @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         addr   <= '0;
         dir_dn <= 1'b0;
      end else if (cnt_load) begin
         addr   <= cnt_down ? '1 : '0;   // top address or zero
         dir_dn <= cnt_down;
      end else if (cnt_en) begin
         if (dir_dn) addr <= addr - 1'b1;
         else        addr <= addr + 1'b1;
      end
   end

   // end address for the direction in use
   assign cnt_last = dir_dn ? (addr == '0) : (addr == '1);

endmodule

// File: logic/mbist_checker.sv
`timescale 1ns/1ps

// pattern source and read compare for the march
// expected data rides a rd_latency deep pipe beside the array read

module mbist_checker (
   input  logic                          rd_ssclk,
   input  logic                          arst_n,
   input  rf_pkg::march_state_t          state,
   input  logic [rf_pkg::rf_addr_w-1:0]  addr,
   input  logic [rf_pkg::rf_width-1:0]   bg_pattern,
   input  logic [rf_pkg::rf_width-1:0]   rd_data,
   input  logic                          bist_csn_rd,
   output logic [rf_pkg::rf_width-1:0]   wdata,
   output logic                          bist_fail,
   output logic [rf_pkg::rf_addr_w-1:0]  fail_addr
);

   localparam int LAT = rf_pkg::rd_latency;

   logic [rf_pkg::rf_width-1:0]  exp_pipe  [LAT];
   logic [rf_pkg::rf_addr_w-1:0] addr_pipe [LAT];
   logic [LAT-1:0]               vld_pipe;   // read issued at that stage
   logic                         inv_elem;
   logic                         mismatch;

   // inverse elements write and expect ~bg_pattern
   assign inv_elem = (state == rf_pkg::w_inv_dn) || (state == rf_pkg::r_inv_dn);
   assign wdata    = inv_elem ? ~bg_pattern : bg_pattern;

   ////////////////////
   // compare pipe
   ////////////////////
   always_ff @(posedge rd_ssclk) begin
      exp_pipe[0]  <= wdata;   // stage 0 lines up with the rf input flops
      addr_pipe[0] <= addr;
      for (int i = 1; i < LAT; i++) begin
         exp_pipe[i]  <= exp_pipe[i-1];
         addr_pipe[i] <= addr_pipe[i-1];
      end
   end

   always_ff @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe[0] <= !bist_csn_rd;
         for (int i = 1; i < LAT; i++) vld_pipe[i] <= vld_pipe[i-1];
      end
   end

   assign mismatch = vld_pipe[LAT-1] && (rd_data != exp_pipe[LAT-1]);

   // sticky fail, first address wins, cleared as a new run starts
   always_ff @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         bist_fail <= 1'b0;
         fail_addr <= '0;
      end else if (state == rf_pkg::w_bg_up) begin
         bist_fail <= 1'b0;
         fail_addr <= '0;
      end else if (mismatch && !bist_fail) begin
         bist_fail <= 1'b1;
         fail_addr <= addr_pipe[LAT-1];
      end
   end

endmodule

// File: logic/rf_subsys_top.sv
`timescale 1ns/1ps

// register file with march self-test
// the engine takes over the rf request port while bist_busy is high

module rf_subsys_top #(
   parameter int RF_WIDTH = rf_pkg::rf_width,
   parameter int RF_DEPTH = rf_pkg::rf_depth,
   parameter int ADDR_W   = rf_pkg::rf_addr_w
) (
   input  logic                rd_ssclk,
   input  logic                arst_n,
   input  logic                csn_rd,
   input  logic                csn_wr,
   input  logic [ADDR_W-1:0]   rd_a,
   input  logic [ADDR_W-1:0]   wr_a,
   input  logic [RF_WIDTH-1:0] di,
   input  logic                hold,
   input  logic                testmux_sel,
   input  logic                scan_en,
   input  logic                si,
   input  logic                bist_start,
   input  logic [RF_WIDTH-1:0] bg_pattern,
   output logic [RF_WIDTH-1:0] rd_data,
   output logic [RF_WIDTH-1:0] listen_out,
   output logic                so,
   output logic                bist_busy,
   output logic                bist_done,
   output logic                bist_fail,
   output logic [ADDR_W-1:0]   fail_addr
);

   rf_pkg::march_state_t state;
   logic                 cnt_en;
   logic                 cnt_down;
   logic                 cnt_load;
   logic                 cnt_last;
   logic                 bist_csn_rd;
   logic                 bist_csn_wr;
   logic [ADDR_W-1:0]    bist_addr;    // shared by read and write
   logic [RF_WIDTH-1:0]  bist_wdata;

   // selected request into the macro
   logic                 rf_csn_rd;
   logic                 rf_csn_wr;
   logic [ADDR_W-1:0]    rf_rd_a;
   logic [ADDR_W-1:0]    rf_wr_a;
   logic [RF_WIDTH-1:0]  rf_di;

   ////////////////////
   // port mux
   ////////////////////
   assign rf_csn_rd = bist_busy ? bist_csn_rd : csn_rd;
   assign rf_csn_wr = bist_busy ? bist_csn_wr : csn_wr;
   assign rf_rd_a   = bist_busy ? bist_addr   : rd_a;
   assign rf_wr_a   = bist_busy ? bist_addr   : wr_a;
   assign rf_di     = bist_busy ? bist_wdata  : di;

   mbist_ctrl u_ctrl (
      .rd_ssclk   (rd_ssclk),
      .arst_n     (arst_n),
      .bist_start (bist_start),
      .cnt_last   (cnt_last),
      .state      (state),
      .cnt_en     (cnt_en),
      .cnt_down   (cnt_down),
      .cnt_load   (cnt_load),
      .bist_csn_rd(bist_csn_rd),
      .bist_csn_wr(bist_csn_wr),
      .bist_busy  (bist_busy),
      .bist_done  (bist_done)
   );

   mbist_addr_cnt #(.ADDR_W(ADDR_W)) u_addr_cnt (
      .rd_ssclk(rd_ssclk),
      .arst_n  (arst_n),
      .cnt_en  (cnt_en),
      .cnt_down(cnt_down),
      .cnt_load(cnt_load),
      .addr    (bist_addr),
      .cnt_last(cnt_last)
   );

   mbist_checker u_checker (
      .rd_ssclk   (rd_ssclk),
      .arst_n     (arst_n),
      .state      (state),
      .addr       (bist_addr),
      .bg_pattern (bg_pattern),
      .rd_data    (rd_data),     // compared at the macro output
      .bist_csn_rd(bist_csn_rd),
      .wdata      (bist_wdata),
      .bist_fail  (bist_fail),
      .fail_addr  (fail_addr)
   );

   rf_16x65 #(.RF_WIDTH(RF_WIDTH), .RF_DEPTH(RF_DEPTH)) u_rf (
      .rd_ssclk   (rd_ssclk),
      .arst_n     (arst_n),
      .csn_rd     (rf_csn_rd),
      .csn_wr     (rf_csn_wr),
      .hold       (hold),
      .testmux_sel(testmux_sel),
      .scan_en    (scan_en),
      .si         (si),
      .rd_a       (rf_rd_a),
      .wr_a       (rf_wr_a),
      .di         (rf_di),
      .so         (so),
      .rd_data    (rd_data),
      .listen_out (listen_out)
   );

endmodule

// File: bench/rf_monitor.sv
`timescale 1ns/1ps

// watches the subsystem ports and predicts every output from a cycle model
// model updates on the rising edge and compares on the falling edge

module rf_monitor (
   input  logic                         rd_ssclk,
   input  logic                         arst_n,
   input  logic                         csn_rd,
   input  logic                         csn_wr,
   input  logic [rf_pkg::rf_addr_w-1:0] rd_a,
   input  logic [rf_pkg::rf_addr_w-1:0] wr_a,
   input  logic [rf_pkg::rf_width-1:0]  di,
   input  logic                         hold,
   input  logic                         testmux_sel,
   input  logic                         scan_en,
   input  logic                         si,
   input  logic                         bist_start,
   input  logic [rf_pkg::rf_width-1:0]  bg_pattern,
   input  logic [rf_pkg::rf_width-1:0]  rd_data,
   input  logic [rf_pkg::rf_width-1:0]  listen_out,
   input  logic                         so,
   input  logic                         bist_busy,
   input  logic                         bist_done,
   input  logic                         bist_fail,
   input  logic [rf_pkg::rf_addr_w-1:0] fail_addr,
   input  logic                         exp_vld,    // table row value check
   input  logic [rf_pkg::rf_width-1:0]  exp_data,
   input  int                           test_id,
   output int                           checks,
   output int                           errors
);

   localparam int W        = rf_pkg::rf_width;
   localparam int AW       = rf_pkg::rf_addr_w;
   localparam int BIST_LEN = 4 * rf_pkg::rf_depth + rf_pkg::rd_latency + 1;   // 67

   logic [W-1:0]  mem [rf_pkg::rf_depth];   // reference array
   logic          q_csn_rd, q_csn_wr;       // model of the sampled request
   logic [AW-1:0] q_rd_a, q_wr_a;
   logic [W-1:0]  q_di;
   logic          di_known, out_known, prev_known, busy_old, shifted;
   logic [W-1:0]  out_m, exp_rd, prev_exp;
   logic          running, done_exp;        // self-test in flight and result expected
   int            run_cnt;
   bit            hist[$];                  // every si bit shifted in
   logic          e1_vld, e2_vld;
   logic [W-1:0]  e1, e2;
   int            n_checks = 0, n_errors = 0, t_checks = 0, t_errors = 0, cur_test = 0;

   assign checks = n_checks;
   assign errors = n_errors;

   task automatic compare(input string name, input logic [W-1:0] got, input logic [W-1:0] want);
      n_checks++;
      t_checks++;
      if (got !== want) begin
         n_errors++;
         t_errors++;
         $display("ERROR %s: got %h, expected %h at %0t", name, got, want, $time);
      end
   endtask

   ////////////////////
   // cycle model
   ////////////////////
   always @(posedge rd_ssclk or negedge arst_n) begin
      if (!arst_n) begin
         q_csn_rd  = 1'b1;   // no access out of reset
         q_csn_wr  = 1'b1;
         di_known  = 1'b0;
         out_known = 1'b0;
         shifted   = 1'b0;
         running   = 1'b0;
         done_exp  = 1'b0;
         run_cnt   = 0;
         e1_vld    = 1'b0;
         e2_vld    = 1'b0;
      end else begin
         busy_old = running;
         if (busy_old) begin
            out_known = 1'b0;                  // engine owns the port
         end else begin
            if (!q_csn_rd && !scan_en) out_m = mem[q_rd_a];
            else                       out_m = '1;
            out_known = 1'b1;
            if (!q_csn_wr && !scan_en) mem[q_wr_a] = q_di;
         end
         if (running) begin
            run_cnt++;
            if (run_cnt == BIST_LEN) begin
               running  = 1'b0;
               done_exp = 1'b1;
               // last write pass leaves the inverse everywhere
               for (int i = 0; i < rf_pkg::rf_depth; i++) mem[i] = ~bg_pattern;
            end
         end else if (bist_start) begin
            running  = 1'b1;
            run_cnt  = 0;
            done_exp = 1'b0;
         end
         shifted = 1'b0;
         if (busy_old) begin
            q_csn_rd = 1'b1;
            q_csn_wr = 1'b1;
            di_known = 1'b0;
         end else if (hold) begin
            // request kept and performed again next edge
         end else if (scan_en) begin
            q_csn_rd = 1'b1;   // selects end high
            q_csn_wr = 1'b1;
            di_known = 1'b0;
            hist.push_back(si);
            shifted = 1'b1;
         end else begin
            q_csn_rd = csn_rd;
            q_csn_wr = csn_wr;
            q_rd_a   = rd_a;
            q_wr_a   = wr_a;
            q_di     = di;
            di_known = 1'b1;
         end
         e2_vld = e1_vld;   // rd_latency deep table pipe
         e2     = e1;
         e1_vld = exp_vld;
         e1     = exp_data;
      end
   end

   ////////////////////
   // compares
   ////////////////////
   always @(negedge rd_ssclk) begin
      if (test_id != cur_test) begin
         if (cur_test != 0)
            $display("test %0d finished: %0d checks, %0d errors", cur_test, t_checks, t_errors);
         cur_test = test_id;
         t_checks = 0;
         t_errors = 0;
      end
      if (!arst_n) begin
         prev_known = 1'b0;
      end else begin
         if (running) begin
            compare("bist_busy", W'(bist_busy), W'(1'b1));
            compare("bist_done", W'(bist_done), W'(1'b0));
         end else if (done_exp) begin
            compare("bist_busy", W'(bist_busy), W'(1'b0));
            compare("bist_done", W'(bist_done), W'(1'b1));
            compare("bist_fail", W'(bist_fail), W'(1'b0));
            compare("fail_addr", W'(fail_addr), '0);   // no failing address recorded
         end
         if (out_known && !(testmux_sel && !di_known)) begin
            exp_rd = testmux_sel ? q_di : out_m;   // bypass shows the sampled di
            compare("rd_data", rd_data, exp_rd);
            if (prev_known) compare("listen_out", listen_out, prev_exp);
            prev_exp   = exp_rd;
            prev_known = 1'b1;
         end else begin
            prev_known = 1'b0;
         end
         if (e2_vld) compare("rd_data", rd_data, e2);
         if (shifted && hist.size() >= rf_pkg::scan_len)
            compare("so", W'(so), W'(hist[hist.size() - rf_pkg::scan_len]));
      end
   end

endmodule

// File: bench/tb_rf_top.sv
`timescale 1ns/1ps

// testbench for rf_subsys_top
// drives a table of port operations, a scan pass and one self-test run

module tb_rf_top;

   localparam int W        = rf_pkg::rf_width;
   localparam int AW       = rf_pkg::rf_addr_w;
   localparam int BIST_LEN = 4 * rf_pkg::rf_depth + rf_pkg::rd_latency + 1;

   localparam logic [1:0] OP_NOP = 2'd0;
   localparam logic [1:0] OP_WR  = 2'd1;
   localparam logic [1:0] OP_RD  = 2'd2;

   // one table row whose expected value lands rd_latency edges after the sample edge
   typedef struct packed {
      int          test;
      logic [1:0]  op;
      logic [AW-1:0] addr;
      logic [W-1:0]  data;
      logic        hold;
      logic        tmux;
      logic        chk;
      logic [W-1:0]  exp;
   } row_t;

   logic          rd_ssclk;
   logic          arst_n;
   logic          csn_rd, csn_wr;
   logic [AW-1:0] rd_a, wr_a;
   logic [W-1:0]  di;
   logic          hold, testmux_sel, scan_en, si, bist_start;
   logic [W-1:0]  bg_pattern;
   logic [W-1:0]  rd_data, listen_out;
   logic          so, bist_busy, bist_done, bist_fail;
   logic [AW-1:0] fail_addr;
   logic          exp_vld;        // row expects a value on rd_data
   logic [W-1:0]  exp_data;
   int            test_id;
   int            mon_checks, mon_errors;

   row_t          rows[$];
   logic [W-1:0]  shadow [rf_pkg::rf_depth];   // expected array contents at build time
   logic [31:0]   rng = 32'he499_d913;
   int            cycles = 0;
   int            cycle_limit = 1000;

   rf_subsys_top DUT (
      .rd_ssclk(rd_ssclk), .arst_n(arst_n),
      .csn_rd(csn_rd), .csn_wr(csn_wr), .rd_a(rd_a), .wr_a(wr_a), .di(di),
      .hold(hold), .testmux_sel(testmux_sel), .scan_en(scan_en), .si(si),
      .bist_start(bist_start), .bg_pattern(bg_pattern),
      .rd_data(rd_data), .listen_out(listen_out), .so(so),
      .bist_busy(bist_busy), .bist_done(bist_done), .bist_fail(bist_fail),
      .fail_addr(fail_addr)
   );

   rf_monitor u_monitor (
      .rd_ssclk(rd_ssclk), .arst_n(arst_n),
      .csn_rd(csn_rd), .csn_wr(csn_wr), .rd_a(rd_a), .wr_a(wr_a), .di(di),
      .hold(hold), .testmux_sel(testmux_sel), .scan_en(scan_en), .si(si),
      .bist_start(bist_start), .bg_pattern(bg_pattern),
      .rd_data(rd_data), .listen_out(listen_out), .so(so),
      .bist_busy(bist_busy), .bist_done(bist_done), .bist_fail(bist_fail),
      .fail_addr(fail_addr),
      .exp_vld(exp_vld), .exp_data(exp_data), .test_id(test_id),
      .checks(mon_checks), .errors(mon_errors)
   );

   always #5 rd_ssclk = ~rd_ssclk;   // 10 ns period

   ////////////////////
   // helpers
   ////////////////////
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [W-1:0] rand_word();
      logic [95:0] raw;
      raw = {next_rand(), next_rand(), next_rand()};
      return raw[W-1:0];
   endfunction

   task automatic add_row(input int t, input logic [1:0] op, input int a,
                          input logic [W-1:0] d, input logic hd, input logic tm,
                          input logic ck, input logic [W-1:0] e);
      row_t r;
      r.test = t;
      r.op   = op;
      r.addr = AW'(a);
      r.data = d;
      r.hold = hd;
      r.tmux = tm;
      r.chk  = ck;
      r.exp  = e;
      rows.push_back(r);
   endtask

   task automatic drive_idle();
      @(posedge rd_ssclk);
      csn_rd      <= 1'b1;
      csn_wr      <= 1'b1;
      hold        <= 1'b0;
      testmux_sel <= 1'b0;
      exp_vld     <= 1'b0;
   endtask

   // applies every row of one test at one row per cycle
   task automatic apply_test(input int t);
      foreach (rows[i]) begin
         if (rows[i].test == t) begin
            @(posedge rd_ssclk);
            test_id     <= t;
            csn_rd      <= (rows[i].op != OP_RD);
            csn_wr      <= (rows[i].op != OP_WR);
            rd_a        <= rows[i].addr;
            wr_a        <= rows[i].addr;
            di          <= rows[i].data;
            hold        <= rows[i].hold;
            testmux_sel <= rows[i].tmux;
            exp_vld     <= rows[i].chk;
            exp_data    <= rows[i].exp;
         end
      end
      repeat (3) drive_idle();   // let the read pipe empty
   endtask

   // two passes of the chain, the second leaving both chip select bits high
   task automatic run_scan();
      logic        b;
      logic [31:0] r;
      for (int k = 0; k < 2 * rf_pkg::scan_len; k++) begin
         r = next_rand();
         b = r[0];
         // bit k ends at chain position k - scan_len
         if (k == rf_pkg::scan_len + AW || k == rf_pkg::scan_len + AW + 1 + W) b = 1'b1;
         @(posedge rd_ssclk);
         scan_en <= 1'b1;
         si      <= b;
      end
      @(posedge rd_ssclk);
      scan_en <= 1'b0;
      si      <= 1'b0;
   endtask

   ////////////////////
   // stimulus table
   ////////////////////
   task automatic build_table();
      logic [W-1:0] d;
      for (int a = 0; a < rf_pkg::rf_depth; a++) begin   // test 1 fills then reads back
         d = rand_word();
         shadow[a] = d;
         add_row(1, OP_WR, a, d, 0, 0, 0, '0);
      end
      for (int a = 0; a < rf_pkg::rf_depth; a++) add_row(1, OP_RD, a, '0, 0, 0, 1, shadow[a]);
      add_row(2, OP_NOP, 0, '0, 0, 0, 1, '1);              // idle read port gives ones
      add_row(2, OP_NOP, 0, '0, 0, 0, 0, '0);
      add_row(2, OP_NOP, 0, '0, 0, 0, 0, '0);
      add_row(2, OP_NOP, 0, rand_word(), 0, 1, 0, '0);     // bypass shows the sampled di
      add_row(2, OP_NOP, 0, rand_word(), 0, 1, 0, '0);
      add_row(2, OP_NOP, 0, '0, 0, 0, 0, '0);
      add_row(3, OP_RD, 5, '0, 0, 0, 1, shadow[5]);
      for (int h = 0; h < 3; h++) add_row(3, OP_WR, 5, rand_word(), 1, 0, 1, shadow[5]);
      add_row(3, OP_NOP, 0, '0, 0, 0, 0, '0);
      add_row(3, OP_RD, 5, '0, 0, 0, 1, shadow[5]);        // held write never landed
      for (int a = 0; a < rf_pkg::rf_depth; a++) add_row(4, OP_RD, a, '0, 0, 0, 1, shadow[a]);
      bg_pattern = rand_word();
      for (int a = 0; a < rf_pkg::rf_depth; a++) add_row(5, OP_RD, a, '0, 0, 0, 1, ~bg_pattern);
   endtask

   // run limit from the table, the scan pass and one march
   always @(posedge rd_ssclk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $finish;
      end
   end

   initial begin
      rd_ssclk    = 1'b0;
      arst_n      = 1'b0;
      csn_rd      = 1'b1;
      csn_wr      = 1'b1;
      rd_a        = '0;
      wr_a        = '0;
      di          = '0;
      hold        = 1'b0;
      testmux_sel = 1'b0;
      scan_en     = 1'b0;
      si          = 1'b0;
      bist_start  = 1'b0;
      bg_pattern  = '0;
      exp_vld     = 1'b0;
      exp_data    = '0;
      test_id     = 0;
      build_table();
      cycle_limit = 10 + rows.size() + 15 + 2 * rf_pkg::scan_len + BIST_LEN + 200;
      repeat (10) @(posedge rd_ssclk);
      arst_n <= 1'b1;
      repeat (3) drive_idle();
      apply_test(1);
      apply_test(2);
      apply_test(3);
      @(posedge rd_ssclk);
      test_id <= 4;
      run_scan();
      apply_test(4);
      @(posedge rd_ssclk);
      test_id    <= 5;
      bist_start <= 1'b1;                 // single cycle start pulse
      @(posedge rd_ssclk);
      bist_start <= 1'b0;
      while (!bist_done) @(posedge rd_ssclk);
      apply_test(5);
      @(posedge rd_ssclk);
      test_id <= 0;                       // closes the last test line
      repeat (3) @(posedge rd_ssclk);
      $display("summary: %0d checks, %0d errors", mon_checks, mon_errors);
      if (mon_errors == 0 && mon_checks > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: files.f
common/rf_pkg.sv
rf_array/rf_16x65.sv
logic/mbist_ctrl.sv
logic/mbist_addr_cnt.sv
logic/mbist_checker.sv
logic/rf_subsys_top.sv
bench/rf_monitor.sv
bench/tb_rf_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
   -f files.f \
   --top-module tb_rf_top \
   -Mdir obj_dir -o sim_rf

./obj_dir/sim_rf | tee sim.log

if grep -q "Verification failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
